// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --timing --assert
TOP       = cpu_exec_top_tb
FILELIST  = cpu_exec_top.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = Test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== cpu_exec_top.f ====
rtl/cpu_pkg.sv
rtl/cpu_alu.sv
rtl/cpu_decoder.sv
rtl/cpu_registers.sv
rtl/cpu_exec_sequencer.sv
rtl/cpu_exec_top.sv
test/cpu_exec_top_sva.sv
test/cpu_exec_top_tb.sv

// ==== rtl/cpu_alu.sv ====
`timescale 1ns/1ps

module cpu_alu (
        input  cpu_pkg::alu_op_e         i_op,
        input  logic [cpu_pkg::XLEN-1:0] i_a,
        input  logic [cpu_pkg::XLEN-1:0] i_b,
        output logic [cpu_pkg::XLEN-1:0] o_result
);
        import cpu_pkg::*;

        logic signed [XLEN-1:0] a_s;
        logic signed [XLEN-1:0] b_s;
        logic [4:0]             shamt;
        logic                   lt_s;
        logic                   lt_u;

        assign a_s   = i_a;
        assign b_s   = i_b;
        assign shamt = i_b[4:0];
        assign lt_s  = a_s < b_s;
        assign lt_u  = i_a < i_b;

        always_comb begin
                case (i_op)
                        ALU_ADD:  o_result = i_a + i_b;
                        ALU_SUB:  o_result = i_a - i_b;
                        ALU_SLL:  o_result = i_a << shamt;
                        ALU_SLT:  o_result = {{(XLEN-1){1'b0}}, lt_s};
                        ALU_SLTU: o_result = {{(XLEN-1){1'b0}}, lt_u};
                        ALU_XOR:  o_result = i_a ^ i_b;
                        ALU_SRL:  o_result = i_a >> shamt;
                        ALU_SRA:  o_result = a_s >>> shamt; // Sign fill
                        ALU_OR:   o_result = i_a | i_b;
                        ALU_AND:  o_result = i_a & i_b;
                        default:  o_result = '0;
                endcase
        end

endmodule

// ==== rtl/cpu_decoder.sv ====
`timescale 1ns/1ps

module cpu_decoder (
        input  logic [cpu_pkg::XLEN-1:0]      i_instr,
        output logic [cpu_pkg::REG_IDX_W-1:0] o_rs1_idx,
        output logic [cpu_pkg::REG_IDX_W-1:0] o_rs2_idx,
        output logic [cpu_pkg::REG_IDX_W-1:0] o_rd_idx,
        output logic [cpu_pkg::XLEN-1:0]      o_imm,
        output logic                          o_use_imm,
        output cpu_pkg::alu_op_e              o_alu_op,
        output logic                          o_illegal
);
        import cpu_pkg::*;

        logic [6:0]      opcode;
        logic [2:0]      funct3;
        logic [6:0]      funct7;
        logic [XLEN-1:0] imm_i;
        logic [XLEN-1:0] imm_u;

        // Shared funct3 mapping for OP and OP-IMM
        function automatic alu_op_e base_op(input logic [2:0] f3, input logic alt);
                alu_op_e op;
                case (f3)
                        F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
                        F3_SLL:  op = ALU_SLL;
                        F3_SLT:  op = ALU_SLT;
                        F3_SLTU: op = ALU_SLTU;
                        F3_XOR:  op = ALU_XOR;
                        F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
                        F3_OR:   op = ALU_OR;
                        default: op = ALU_AND;
                endcase
                return op;
        endfunction

        assign opcode = i_instr[6:0];
        assign funct3 = i_instr[14:12];
        assign funct7 = i_instr[31:25];
        assign imm_i  = {{(XLEN-12){i_instr[31]}}, i_instr[31:20]};
        assign imm_u  = {i_instr[31:12], 12'b0};

        always_comb begin
                o_rs1_idx = i_instr[19:15];
                o_rs2_idx = i_instr[24:20];
                o_rd_idx  = i_instr[11:7];
                o_imm     = imm_i;
                o_use_imm = 1'b0;
                o_alu_op  = ALU_ADD;
                o_illegal = 1'b0;

                case (opcode)
                        OPC_OP: begin
                                o_alu_op = base_op(funct3, funct7 == F7_ALT);
                                if (funct7 == F7_ALT)
                                        o_illegal = (funct3 != F3_ADD) && (funct3 != F3_SR);
                                else
                                        o_illegal = (funct7 != F7_BASE);
                        end
                        OPC_OP_IMM: begin
                                o_use_imm = 1'b1;
                                o_alu_op  = base_op(funct3, (funct3 == F3_SR) && (funct7 == F7_ALT));
                                if (funct3 == F3_SLL)
                                        o_illegal = (funct7 != F7_BASE);
                                else if (funct3 == F3_SR)
                                        o_illegal = (funct7 != F7_BASE) && (funct7 != F7_ALT);
                        end
                        OPC_LUI: begin
                                o_rs1_idx = '0; // x0 + imm
                                o_imm     = imm_u;
                                o_use_imm = 1'b1;
                        end
                        default: o_illegal = 1'b1;
                endcase
        end

endmodule

// ==== rtl/cpu_exec_sequencer.sv ====
`timescale 1ns/1ps

module cpu_exec_sequencer (
        input  logic                          i_clock,
        input  logic                          i_reset,

        input  logic                          i_instr_valid,
        input  logic [cpu_pkg::XLEN-1:0]      i_instr,
        output logic                          o_instr_ready,
        output logic [cpu_pkg::XLEN-1:0]      o_instr_q,

        input  logic [cpu_pkg::REG_IDX_W-1:0] i_rd_idx,
        input  logic                          i_illegal,
        input  logic [cpu_pkg::XLEN-1:0]      i_alu_result,

        output logic [cpu_pkg::TAG_W-1:0]     o_read_tag,
        output logic [cpu_pkg::TAG_W-1:0]     o_write_tag,
        output logic [cpu_pkg::REG_IDX_W-1:0] o_write_rd_idx,
        output logic [cpu_pkg::XLEN-1:0]      o_write_data,

        output logic                          o_retire_valid,
        input  logic                          i_retire_ready,
        output logic [cpu_pkg::REG_IDX_W-1:0] o_retire_rd,
        output logic [cpu_pkg::XLEN-1:0]      o_retire_value,
        output logic                          o_retire_illegal
);
        import cpu_pkg::*;

        seq_state_e           state;
        logic                 read_issued; // Read tag bumped, operands due next edge
        logic [XLEN-1:0]      instr_q;
        logic [REG_IDX_W-1:0] rd_q;
        logic [XLEN-1:0]      result_q;
        logic                 illegal_q;

        // ####################################################################
        // Control FSM and tag counters
        // ####################################################################
        always_ff @(posedge i_clock, posedge i_reset) begin
                if (i_reset) begin
                        state       <= SEQ_IDLE;
                        read_issued <= 1'b0;
                        o_read_tag  <= '0;
                        o_write_tag <= '0;
                end else begin
                        case (state)
                                SEQ_IDLE: begin
                                        if (i_instr_valid)
                                                state <= SEQ_READ;
                                end
                                SEQ_READ: begin
                                        if (!read_issued) begin
                                                o_read_tag  <= o_read_tag + 1'b1;
                                                read_issued <= 1'b1;
                                        end else begin
                                                read_issued <= 1'b0;
                                                state       <= SEQ_EXEC;
                                        end
                                end
                                SEQ_EXEC: begin
                                        if (!i_illegal)
                                                o_write_tag <= o_write_tag + 1'b1;
                                        state <= SEQ_RETIRE;
                                end
                                SEQ_RETIRE: begin
                                        if (i_retire_ready)
                                                state <= SEQ_IDLE;
                                end
                                default: state <= SEQ_IDLE;
                        endcase
                end
        end

        // ####################################################################
        // Instruction and result holding registers
        // ####################################################################
        always_ff @(posedge i_clock) begin
                if (state == SEQ_IDLE && i_instr_valid)
                        instr_q <= i_instr;
                if (state == SEQ_EXEC) begin
                        rd_q      <= i_rd_idx;
                        result_q  <= i_alu_result;
                        illegal_q <= i_illegal;
                end
        end

        assign o_instr_ready    = (state == SEQ_IDLE);
        assign o_instr_q        = instr_q;

        assign o_write_rd_idx   = rd_q;     // Same registers feed write-back and retire
        assign o_write_data     = result_q;

        assign o_retire_valid   = (state == SEQ_RETIRE);
        assign o_retire_rd      = rd_q;
        assign o_retire_value   = result_q;
        assign o_retire_illegal = illegal_q;

endmodule

// ==== rtl/cpu_exec_top.sv ====
`timescale 1ns/1ps

module cpu_exec_top (
        input  logic                          i_clock,
        input  logic                          i_reset,

        input  logic                          i_instr_valid,
        input  logic [cpu_pkg::XLEN-1:0]      i_instr,
        output logic                          o_instr_ready,

        output logic                          o_retire_valid,
        input  logic                          i_retire_ready,
        output logic [cpu_pkg::REG_IDX_W-1:0] o_retire_rd,
        output logic [cpu_pkg::XLEN-1:0]      o_retire_value,
        output logic                          o_retire_illegal
);
        import cpu_pkg::*;

        logic [XLEN-1:0]      instr_q;
        logic [REG_IDX_W-1:0] rs1_idx;
        logic [REG_IDX_W-1:0] rs2_idx;
        logic [REG_IDX_W-1:0] rd_idx;
        logic [XLEN-1:0]      imm;
        logic                 use_imm;
        alu_op_e              alu_op;
        logic                 illegal;

        logic [TAG_W-1:0]     read_tag;
        logic [TAG_W-1:0]     write_tag;
        logic [REG_IDX_W-1:0] write_rd_idx;
        logic [XLEN-1:0]      write_data;
        logic [XLEN-1:0]      rs1_data;
        logic [XLEN-1:0]      rs2_data;
        logic [XLEN-1:0]      alu_result;

        cpu_exec_sequencer u_sequencer (
                .i_clock          (i_clock),
                .i_reset          (i_reset),
                .i_instr_valid    (i_instr_valid),
                .i_instr          (i_instr),
                .o_instr_ready    (o_instr_ready),
                .o_instr_q        (instr_q),
                .i_rd_idx         (rd_idx),
                .i_illegal        (illegal),
                .i_alu_result     (alu_result),
                .o_read_tag       (read_tag),
                .o_write_tag      (write_tag),
                .o_write_rd_idx   (write_rd_idx),
                .o_write_data     (write_data),
                .o_retire_valid   (o_retire_valid),
                .i_retire_ready   (i_retire_ready),
                .o_retire_rd      (o_retire_rd),
                .o_retire_value   (o_retire_value),
                .o_retire_illegal (o_retire_illegal)
        );

        cpu_decoder u_decoder (
                .i_instr   (instr_q),
                .o_rs1_idx (rs1_idx),
                .o_rs2_idx (rs2_idx),
                .o_rd_idx  (rd_idx),
                .o_imm     (imm),
                .o_use_imm (use_imm),
                .o_alu_op  (alu_op),
                .o_illegal (illegal)
        );

        cpu_registers u_registers (
                .i_clock        (i_clock),
                .i_reset        (i_reset),
                .i_read_tag     (read_tag),
                .i_read_rs1_idx (rs1_idx),
                .i_read_rs2_idx (rs2_idx),
                .o_rs1          (rs1_data),
                .o_rs2          (rs2_data),
                .i_write_tag    (write_tag),
                .i_write_rd_idx (write_rd_idx),
                .i_rd           (write_data)
        );

        cpu_alu u_alu (
                .i_op     (alu_op),
                .i_a      (rs1_data),
                .i_b      (use_imm ? imm : rs2_data), // Operand B select
                .o_result (alu_result)
        );

endmodule

// ==== rtl/cpu_pkg.sv ====
package cpu_pkg;

        // ####################################################################
        // Sizes and reset layout
        // ####################################################################
        localparam int XLEN      = 32;
        localparam int REG_IDX_W = 5;
        localparam int TAG_W     = 2;

        localparam logic [XLEN-1:0] SP_RESET = 32'h1000_03FC; // Top of RAM minus one word

        // ####################################################################
        // Instruction encodings
        // ####################################################################
        localparam logic [6:0] OPC_OP     = 7'b0110011;
        localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
        localparam logic [6:0] OPC_LUI    = 7'b0110111;

        localparam logic [2:0] F3_ADD  = 3'b000; // ADD and SUB
        localparam logic [2:0] F3_SLL  = 3'b001;
        localparam logic [2:0] F3_SLT  = 3'b010;
        localparam logic [2:0] F3_SLTU = 3'b011;
        localparam logic [2:0] F3_XOR  = 3'b100;
        localparam logic [2:0] F3_SR   = 3'b101; // SRL and SRA
        localparam logic [2:0] F3_OR   = 3'b110;
        localparam logic [2:0] F3_AND  = 3'b111;

        localparam logic [6:0] F7_BASE = 7'b0000000;
        localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB and SRA

        // ####################################################################
        // Enums
        // ####################################################################
        typedef enum logic [3:0] {
                ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
                ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
        } alu_op_e;

        typedef enum logic [1:0] {
                SEQ_IDLE, SEQ_READ, SEQ_EXEC, SEQ_RETIRE
        } seq_state_e;

endpackage

// ==== rtl/cpu_registers.sv ====
`timescale 1ns/1ps

module cpu_registers (
        input  logic                          i_clock,
        input  logic                          i_reset,

        input  logic [cpu_pkg::TAG_W-1:0]     i_read_tag,
        input  logic [cpu_pkg::REG_IDX_W-1:0] i_read_rs1_idx,
        input  logic [cpu_pkg::REG_IDX_W-1:0] i_read_rs2_idx,
        output logic [cpu_pkg::XLEN-1:0]      o_rs1,
        output logic [cpu_pkg::XLEN-1:0]      o_rs2,

        input  logic [cpu_pkg::TAG_W-1:0]     i_write_tag,
        input  logic [cpu_pkg::REG_IDX_W-1:0] i_write_rd_idx,
        input  logic [cpu_pkg::XLEN-1:0]      i_rd
);
        import cpu_pkg::*;

        localparam int NUM_REGS = 1 << REG_IDX_W;

        logic [TAG_W-1:0] read_tag;  // Last read request served
        logic [TAG_W-1:0] write_tag; // Last write request served
        logic [XLEN-1:0]  regs [NUM_REGS];

        always_ff @(posedge i_clock, posedge i_reset) begin
                if (i_reset) begin
                        o_rs1     <= '0;
                        o_rs2     <= '0;
                        read_tag  <= '0;
                        write_tag <= '0;
                        for (int i = 0; i < NUM_REGS; i++) begin
                                regs[i] <= (i == 2) ? SP_RESET : '0; // x2 is sp
                        end
                end else begin
                        if (i_read_tag != read_tag) begin
                                o_rs1    <= (i_read_rs1_idx != '0) ? regs[i_read_rs1_idx] : '0;
                                o_rs2    <= (i_read_rs2_idx != '0) ? regs[i_read_rs2_idx] : '0;
                                read_tag <= i_read_tag;
                        end
                        if (i_write_tag != write_tag) begin
                                regs[i_write_rd_idx] <= i_rd; // x0 is masked on read
                                write_tag            <= i_write_tag;
                        end
                end
        end

endmodule

// ==== test/cpu_exec_top_sva.sv ====
`timescale 1ns/1ps

module cpu_exec_top_sva (
        input  logic                          i_clock,
        input  logic                          i_reset,
        input  logic                          i_instr_valid,
        input  logic                          i_instr_ready,
        input  logic                          i_retire_valid,
        input  logic                          i_retire_ready,
        input  logic [cpu_pkg::REG_IDX_W-1:0] i_retire_rd,
        input  logic [cpu_pkg::XLEN-1:0]      i_retire_value,
        input  logic                          i_retire_illegal
);
        logic accept;

        assign accept = i_instr_valid && i_instr_ready;

        retire_held: assert property (@(posedge i_clock) disable iff (i_reset)
                i_retire_valid && !i_retire_ready |=> i_retire_valid && $stable(i_retire_rd)
                        && $stable(i_retire_value) && $stable(i_retire_illegal))
                else $error("retire port changed while stalled");

        ready_blocked: assert property (@(posedge i_clock) disable iff (i_reset)
                i_retire_valid |-> !i_instr_ready)
                else $error("instruction ready high during retire");

        // Retire valid rises 3 cycles after the accept edge
        retire_latency: assert property (@(posedge i_clock) disable iff (i_reset)
                $rose(i_retire_valid) |-> $past(accept, 4))
                else $error("retire valid rose at the wrong cycle");

        reset_state: assert property (@(posedge i_clock)
                $fell(i_reset) |-> i_instr_ready && !i_retire_valid)
                else $error("handshake outputs wrong after reset");

endmodule

bind cpu_exec_top cpu_exec_top_sva u_sva (
        .i_clock          (i_clock),
        .i_reset          (i_reset),
        .i_instr_valid    (i_instr_valid),
        .i_instr_ready    (o_instr_ready),
        .i_retire_valid   (o_retire_valid),
        .i_retire_ready   (i_retire_ready),
        .i_retire_rd      (o_retire_rd),
        .i_retire_value   (o_retire_value),
        .i_retire_illegal (o_retire_illegal)
);

// ==== test/cpu_exec_top_tb.sv ====
`timescale 1ns/1ps

module cpu_exec_top_tb;
        import cpu_pkg::*;

        localparam int NUM_INSTR  = 43;
        localparam int MAX_CYCLES = 40 * NUM_INSTR + 100;

        logic        i_clock;
        logic        i_reset;
        logic        i_instr_valid;
        logic [31:0] i_instr;
        logic        o_instr_ready;
        logic        o_retire_valid;
        logic        i_retire_ready;
        logic [4:0]  o_retire_rd;
        logic [31:0] o_retire_value;
        logic        o_retire_illegal;

        logic [31:0] model [32]; // Architectural register state
        int          seed;
        int          issued = 0;
        int          retire_count = 0;
        int          cycle_count = 0;

        cpu_exec_top DUT (.*);

        initial begin
                i_clock = 1'b0;
                forever #10 i_clock = ~i_clock;
        end

        always @(negedge i_clock) begin
                if (o_retire_valid && i_retire_ready)
                        retire_count <= retire_count + 1; // Transfer on the coming edge
        end

        always @(posedge i_clock) begin
                cycle_count <= cycle_count + 1;
                assert (cycle_count < MAX_CYCLES) else begin
                        $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
                        $display("Test failed");
                        $fatal(1);
                end
        end

        // ####################################################################
        // Instruction encoding and reference model
        // ####################################################################
        function automatic logic [31:0] op_word(input logic [6:0] f7, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3,
                                                input logic [4:0] rd);
                return {f7, rs2, rs1, f3, rd, OPC_OP};
        endfunction

        function automatic logic [31:0] imm_word(input logic [11:0] imm, input logic [4:0] rs1,
                                                 input logic [2:0] f3, input logic [4:0] rd);
                return {imm, rs1, f3, rd, OPC_OP_IMM};
        endfunction

        function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
                return {imm, rd, OPC_LUI};
        endfunction

        // RV32I integer semantics by funct3
        function automatic logic [31:0] rv32_op(input logic [2:0] f3, input logic alt,
                                                input logic [31:0] a, input logic [31:0] b);
                logic signed [31:0] a_s;
                logic [31:0]        res;
                a_s = a;
                case (f3)
                        3'd0: res = alt ? a - b : a + b;
                        3'd1: res = a << b[4:0];
                        3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        3'd3: res = (a < b) ? 32'd1 : 32'd0;
                        3'd4: res = a ^ b;
                        3'd5: begin
                                if (alt)
                                        res = a_s >>> b[4:0];
                                else
                                        res = a >> b[4:0];
                        end
                        3'd6: res = a | b;
                        default: res = a & b;
                endcase
                return res;
        endfunction

        function automatic void model_instr(input logic [31:0] instr, output logic [31:0] value,
                                            output logic illegal);
                logic [2:0]  f3;
                logic [6:0]  f7;
                logic [31:0] imm;
                f3      = instr[14:12];
                f7      = instr[31:25];
                imm     = {{20{instr[31]}}, instr[31:20]};
                value   = 32'h0;
                illegal = 1'b0;
                if (instr[6:0] == OPC_LUI) begin
                        value = {instr[31:12], 12'h000};
                end else if (instr[6:0] == OPC_OP) begin
                        illegal = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
                        value   = rv32_op(f3, f7[5], model[instr[19:15]], model[instr[24:20]]);
                end else if (instr[6:0] == OPC_OP_IMM) begin
                        if (f3 == 3'd1)
                                illegal = (f7 != 7'h00);
                        if (f3 == 3'd5)
                                illegal = (f7 != 7'h00) && (f7 != 7'h20);
                        value = rv32_op(f3, f3 == 3'd5 && f7[5], model[instr[19:15]], imm);
                end else begin
                        illegal = 1'b1;
                end
        endfunction

        // ####################################################################
        // Drivers and checks
        // ####################################################################
        task automatic check_value(input string test_name, input string what,
                                   input logic [31:0] expected, input logic [31:0] actual);
                assert (expected === actual) else begin
                        $display("Fail %s (%s): expected %h, actual %h",
                                 test_name, what, expected, actual);
                        $display("Test failed");
                        $fatal(1);
                end
        endtask

        // Starts and ends 2 ns after a rising edge
        task automatic run_instr(input string test_name, input logic [31:0] instr,
                                 input int stall);
                logic [31:0] exp_value;
                logic        exp_illegal;
                logic [4:0]  exp_rd;
                exp_rd = instr[11:7];
                model_instr(instr, exp_value, exp_illegal);
                i_retire_ready = (stall == 0);
                i_instr        = instr;
                i_instr_valid  = 1'b1;
                @(negedge i_clock);
                while (!o_instr_ready)
                        @(negedge i_clock);
                @(posedge i_clock); // Accept edge
                #2;
                i_instr_valid = 1'b0;
                issued++;
                @(negedge i_clock);
                while (!o_retire_valid)
                        @(negedge i_clock);
                check_value(test_name, "rd", 32'(exp_rd), 32'(o_retire_rd));
                check_value(test_name, "illegal", 32'(exp_illegal), 32'(o_retire_illegal));
                if (!exp_illegal)
                        check_value(test_name, "value", exp_value, o_retire_value);
                if (stall > 0) begin
                        repeat (stall) @(posedge i_clock);
                        #2;
                        i_retire_ready = 1'b1;
                end
                @(posedge i_clock); // Retire transfer
                #2;
                if (!exp_illegal && exp_rd != 5'd0)
                        model[exp_rd] = exp_value;
        endtask

        task automatic load_reg(input string test_name, input logic [4:0] rd,
                                input logic [31:0] value);
                logic [31:0] upper;
                upper = value + 32'h800; // ADDI sign-extends the low part
                run_instr(test_name, lui_word(upper[31:12], rd), 0);
                run_instr(test_name, imm_word(value[11:0], rd, 3'd0, rd), 0);
        endtask

        // ####################################################################
        // Tests
        // ####################################################################
        task automatic test_reset_state();
                @(negedge i_clock);
                check_value("reset_state", "instr ready", 32'd1, 32'(o_instr_ready));
                check_value("reset_state", "retire valid", 32'd0, 32'(o_retire_valid));
                @(posedge i_clock);
                #2;
                run_instr("reset_state", imm_word(12'h000, 5'd2, 3'd0, 5'd5), 0);
                run_instr("reset_state", op_word(7'h00, 5'd0, 5'd0, 3'd0, 5'd6), 0);
        endtask

        task automatic test_imm_ops();
                logic [31:0] rnd;
                logic [11:0] imm;
                rnd = $random(seed);
                load_reg("imm_ops", 5'd10, rnd);
                for (int i = 0; i < 8; i++) begin
                        rnd = $random(seed);
                        imm = rnd[11:0];
                        if (i == 1 || i == 5)
                                imm[11:5] = 7'h00; // SLLI and SRLI
                        run_instr("imm_ops", imm_word(imm, 5'd10, 3'(i), 5'(11 + i)), 0);
                end
                rnd = $random(seed);
                run_instr("imm_ops", imm_word({7'h20, rnd[4:0]}, 5'd10, 3'd5, 5'd19), 0);
        endtask

        task automatic test_reg_ops();
                logic [31:0] neg;
                logic [31:0] pos;
                neg = $random(seed) | 32'h8000_0000;
                pos = $random(seed) & 32'h7FFF_FFFF;
                load_reg("reg_ops", 5'd20, neg);
                load_reg("reg_ops", 5'd21, pos);
                for (int i = 0; i < 8; i++)
                        run_instr("reg_ops", op_word(7'h00, 5'd21, 5'd20, 3'(i), 5'(23 + i)), 0);
                run_instr("reg_ops", op_word(7'h20, 5'd21, 5'd20, 3'd0, 5'd12), 0); // SUB
                run_instr("reg_ops", op_word(7'h20, 5'd21, 5'd20, 3'd5, 5'd13), 0); // SRA
                run_instr("reg_ops", op_word(7'h00, 5'd20, 5'd21, 3'd2, 5'd14), 0);
                run_instr("reg_ops", op_word(7'h00, 5'd20, 5'd21, 3'd3, 5'd16), 0);
        endtask

        task automatic test_x0();
                run_instr("x0", imm_word(12'h07B, 5'd0, 3'd0, 5'd0), 0);
                run_instr("x0", op_word(7'h00, 5'd0, 5'd0, 3'd0, 5'd7), 0);
        endtask

        task automatic test_backpressure();
                logic [31:0] rnd;
                int          stall;
                for (int i = 0; i < 8; i++) begin
                        stall = $random(seed) & 7;
                        rnd   = $random(seed);
                        run_instr("backpressure", imm_word(rnd[11:0], 5'(20 + i % 2),
                                  (i % 2 == 0) ? 3'd0 : 3'd4, 5'(3 + i)), stall);
                end
                check_value("backpressure", "retired", 32'(issued), 32'(retire_count));
        endtask

        task automatic test_illegal();
                logic [31:0] rnd;
                rnd = $random(seed);
                load_reg("illegal", 5'd9, rnd);
                run_instr("illegal", {12'h004, 5'd9, 3'd2, 5'd9, 7'b0000011}, 0); // LW
                run_instr("illegal", imm_word(12'h000, 5'd9, 3'd0, 5'd15), 0);
        endtask

        initial begin
                seed           = 72;
                i_reset        = 1'b1;
                i_instr_valid  = 1'b0;
                i_instr        = 32'h0;
                i_retire_ready = 1'b1;
                for (int i = 0; i < 32; i++)
                        model[i] = (i == 2) ? SP_RESET : 32'h0;
                repeat (4) @(posedge i_clock);
                #2;
                i_reset = 1'b0;
                test_reset_state();
                test_imm_ops();
                test_reg_ops();
                test_x0();
                test_backpressure();
                test_illegal();
                check_value("summary", "retired", 32'(issued), 32'(retire_count));
                $display("Test passed");
                $finish;
        end

endmodule
